/* cmd/sd_cmd_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module sd_cmd_tx
    import sd_pkg::*;
(
    input  wire       clk_fast,
    input  wire       init_resetPulse,
    input  wire       cmd_start,
    input  wire cmd_req_t cmd_req,
    output line_out_t cmd_out,
    output logic      cmd_done,
    output logic      rx_abort,
    output logic      arm_resp,
    output logic      arm_dat
);

    logic                              active;
    logic [$clog2(CMD_FRAME_BITS)-1:0] bit_cnt;
    logic [CMD_PAYLOAD_BITS-1:0]       shreg;
    logic                              in_payload;
    logic                              in_crc;
    logic                              crc_msb;

    // Bits 47..8 come from the shift register, bits 7..1 from the CRC lane
    assign in_payload = active && (bit_cnt < CMD_PAYLOAD_BITS);
    assign in_crc     = active && (bit_cnt >= CMD_PAYLOAD_BITS)
                               && (bit_cnt < CMD_FRAME_BITS - 1);

    // CRC7 over the payload, then shifted out behind it
    sd_crc_lane #(
        .crc_type (crc7_t),
        .POLY     (CRC7_POLY)
    ) u_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (cmd_start),
        .shift           (in_payload || in_crc),
        .bit_in          (in_payload ? shreg[CMD_PAYLOAD_BITS-1] : crc_msb),
        .crc             (),
        .crc_msb         (crc_msb)
    );

    // ======================================================================
    // Line drive
    // ======================================================================

    always_comb begin
        cmd_out.en = active;
        if (in_payload) begin
            cmd_out.val = shreg[CMD_PAYLOAD_BITS-1];
        end else if (in_crc) begin
            cmd_out.val = crc_msb;
        end else begin
            // End bit, and idle level when not driving
            cmd_out.val = 1'b1;
        end
    end

    // ======================================================================
    // Sequencing
    // ======================================================================

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            active   <= 1'b0;
            bit_cnt  <= '0;
            cmd_done <= 1'b0;
            rx_abort <= 1'b0;
            arm_resp <= 1'b0;
            arm_dat  <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            arm_resp <= 1'b0;
            arm_dat  <= 1'b0;
            // Any receive in flight belongs to the previous command
            rx_abort <= cmd_start;
            if (cmd_start) begin
                active  <= 1'b1;
                bit_cnt <= '0;
            end else if (active) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CMD_FRAME_BITS - 1) begin
                    active   <= 1'b0;
                    cmd_done <= 1'b1;
                    arm_resp <= cmd_req.expect_resp;
                    arm_dat  <= cmd_req.expect_block;
                end
            end
        end
    end

    // Start bit 0, transmission bit 1, then index and argument
    always_ff @(posedge clk_fast) begin
        if (cmd_start) begin
            shreg <= {1'b0, 1'b1, cmd_req.index, cmd_req.arg};
        end else if (in_payload) begin
            shreg <= shreg << 1;
        end
    end

endmodule

`default_nettype wire

/* cmd/sd_resp_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module sd_resp_rx
    import sd_pkg::*;
(
    input  wire   clk_fast,
    input  wire   init_resetPulse,
    input  wire   arm,
    input  wire   abort,
    input  wire   cmd_in,
    output logic  resp_done,
    output resp_t resp
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_HUNT,
        RX_RECV
    } rx_state_t;

    rx_state_t                         state;
    logic [$clog2(CMD_FRAME_BITS)-1:0] bit_cnt;
    logic                              start_seen;
    logic                              last_bit;
    logic                              crc_shift;
    crc7_t                             crc;

    // Start bit counts as frame bit 47
    assign start_seen = (state == RX_HUNT) && !cmd_in;
    assign last_bit   = (state == RX_RECV) && (bit_cnt == CMD_FRAME_BITS - 1);

    // Only bits 47..8 go into the remainder
    assign crc_shift  = start_seen
                     || ((state == RX_RECV) && (bit_cnt < CMD_PAYLOAD_BITS));

    sd_crc_lane #(
        .crc_type (crc7_t),
        .POLY     (CRC7_POLY)
    ) u_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (arm),
        .shift           (crc_shift),
        .bit_in          (cmd_in),
        .crc             (crc),
        .crc_msb         ()
    );

    // ======================================================================
    // Receive FSM
    // ======================================================================

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state     <= RX_IDLE;
            bit_cnt   <= '0;
            resp_done <= 1'b0;
        end else begin
            resp_done <= 1'b0;
            if (abort) begin
                state <= RX_IDLE;
            end else if (arm) begin
                state <= RX_HUNT;
            end else begin
                case (state)
                    RX_HUNT: begin
                        // Card may take any number of cycles to answer
                        if (!cmd_in) begin
                            state   <= RX_RECV;
                            bit_cnt <= 1;
                        end
                    end
                    RX_RECV: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state     <= RX_IDLE;
                            resp_done <= 1'b1;
                        end
                    end
                    default: begin
                        state <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    // ======================================================================
    // Frame capture and check
    // ======================================================================

    always_ff @(posedge clk_fast) begin
        if (start_seen || (state == RX_RECV)) begin
            resp.frame <= {resp.frame[CMD_FRAME_BITS-2:0], cmd_in};
        end
        // Bits 7..1 sit at the bottom of the frame until the end bit arrives
        if (last_bit) begin
            resp.crc_err <= (crc != resp.frame[CRC7_BITS-1:0]) || !cmd_in;
        end
    end

endmodule

`default_nettype wire

/* common/sd_pkg.sv */
`default_nettype none

package sd_pkg;

    // ======================================================================
    // Frame and block sizes
    // ======================================================================

    // Full command or response frame on the cmd line
    localparam int CMD_FRAME_BITS   = 48;

    // Start, transmission, index and argument bits covered by CRC7
    localparam int CMD_PAYLOAD_BITS = 40;

    localparam int CRC7_BITS        = 7;
    localparam int CRC16_BITS       = 16;

    // One 512-byte block spread over DAT[3:0]
    localparam int BLOCK_NIBBLES    = 1024;

    // Nibbles packed into one output word
    localparam int WORD_NIBBLES     = 4;

    // ======================================================================
    // CRC remainders and feedback taps
    // ======================================================================

    typedef logic [CRC7_BITS-1:0]  crc7_t;
    typedef logic [CRC16_BITS-1:0] crc16_t;

    // x^7 + x^3 + 1, top term implied by the shift
    localparam crc7_t  CRC7_POLY  = 7'h09;

    // CCITT x^16 + x^12 + x^5 + 1
    localparam crc16_t CRC16_POLY = 16'h1021;

    // ======================================================================
    // Command, response and line types
    // ======================================================================

    // Command request, held by the requester until the command ends
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        // A 48-bit response follows the command
        logic        expect_resp;
        // A read block follows the command
        logic        expect_block;
    } cmd_req_t;

    // Received response frame, including the card's own CRC field
    typedef struct packed {
        logic [CMD_FRAME_BITS-1:0] frame;
        logic                      crc_err;
    } resp_t;

    // Drive of a bidirectional SD line
    typedef struct packed {
        logic en;
        logic val;
    } line_out_t;

    // First nibble received lands in the upper bits
    typedef logic [WORD_NIBBLES*4-1:0] dat_word_t;

endpackage

`default_nettype wire

/* dat/sd_dat_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module sd_dat_rx
    import sd_pkg::*;
(
    input  wire        clk_fast,
    input  wire        init_resetPulse,
    input  wire        arm,
    input  wire        abort,
    input  wire [3:0]  dat_in,
    output logic       word_valid,
    output dat_word_t  word,
    output logic       dat_done,
    output logic       dat_crc_err
);

    typedef enum logic [2:0] {
        DX_IDLE,
        DX_HUNT,
        DX_DATA,
        DX_CRC,
        DX_END
    } dx_state_t;

    dx_state_t                        state;
    logic [$clog2(BLOCK_NIBBLES)-1:0] nib_cnt;
    logic                             in_data;
    logic                             crc_mismatch;
    crc16_t [3:0]                     lane_crc;
    crc16_t [3:0]                     rx_crc;

    assign in_data = (state == DX_DATA);

    // ======================================================================
    // Per-line CRC16
    // ======================================================================

    for (genvar i = 0; i < 4; i++) begin : g_lane
        sd_crc_lane #(
            .crc_type (crc16_t),
            .POLY     (CRC16_POLY)
        ) u_crc16 (
            .clk_fast        (clk_fast),
            .init_resetPulse (init_resetPulse),
            .clear           (arm),
            .shift           (in_data),
            .bit_in          (dat_in[i]),
            .crc             (lane_crc[i]),
            .crc_msb         ()
        );
    end

    // Any line whose received CRC disagrees with ours
    assign crc_mismatch = (lane_crc != rx_crc);

    // ======================================================================
    // Block FSM
    // ======================================================================

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state      <= DX_IDLE;
            nib_cnt    <= '0;
            word_valid <= 1'b0;
            dat_done   <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            dat_done   <= 1'b0;
            if (abort) begin
                state <= DX_IDLE;
            end else if (arm) begin
                state <= DX_HUNT;
            end else begin
                case (state)
                    DX_HUNT: begin
                        // Start nibble is seen on DAT0
                        if (!dat_in[0]) begin
                            state   <= DX_DATA;
                            nib_cnt <= '0;
                        end
                    end
                    DX_DATA: begin
                        nib_cnt <= nib_cnt + 1'b1;
                        // Low counter bits give the position inside a word
                        if (nib_cnt[$clog2(WORD_NIBBLES)-1:0] == WORD_NIBBLES - 1) begin
                            word_valid <= 1'b1;
                        end
                        // Counter wraps to zero for the CRC phase
                        if (nib_cnt == BLOCK_NIBBLES - 1) begin
                            state <= DX_CRC;
                        end
                    end
                    DX_CRC: begin
                        nib_cnt <= nib_cnt + 1'b1;
                        if (nib_cnt[$clog2(CRC16_BITS)-1:0] == CRC16_BITS - 1) begin
                            state <= DX_END;
                        end
                    end
                    DX_END: begin
                        dat_done <= 1'b1;
                        state    <= DX_IDLE;
                    end
                    default: begin
                        state <= DX_IDLE;
                    end
                endcase
            end
        end
    end

    // ======================================================================
    // Word assembly and CRC capture
    // ======================================================================

    always_ff @(posedge clk_fast) begin
        if (in_data) begin
            word <= {word[11:0], dat_in};
        end
        if (state == DX_CRC) begin
            for (int i = 0; i < 4; i++) begin
                rx_crc[i] <= {rx_crc[i][CRC16_BITS-2:0], dat_in[i]};
            end
        end
        // End nibble must be all ones on every line
        if (state == DX_END) begin
            dat_crc_err <= crc_mismatch || (dat_in != 4'hf);
        end
    end

endmodule

`default_nettype wire

/* design/sd_crc_lane.sv */
`timescale 1ns/1ns
`default_nettype none

// Serial CRC register, MSB-first, shared by the CRC7 and CRC16 users
module sd_crc_lane
    import sd_pkg::*;
#(
    parameter type     crc_type = crc7_t,
    parameter crc_type POLY     = CRC7_POLY
) (
    input  wire     clk_fast,
    input  wire     init_resetPulse,
    input  wire     clear,
    input  wire     shift,
    input  wire     bit_in,
    output crc_type crc,
    output logic    crc_msb
);

    logic feedback;

    // Top bit of the remainder, next bit to go out on a transmitter
    assign crc_msb  = crc[$bits(crc_type)-1];

    // Feeding crc_msb back as bit_in turns the LFSR into a plain shifter
    assign feedback = bit_in ^ crc_msb;

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse || clear) begin
            crc <= '0;
        end else if (shift) begin
            crc <= crc_type'({crc[$bits(crc_type)-2:0], 1'b0})
                 ^ (feedback ? POLY : crc_type'(0));
        end
    end

endmodule

`default_nettype wire

/* design/sd_host.sv */
`timescale 1ns/1ns
`default_nettype none

module sd_host
    import sd_pkg::*;
(
    input  wire       clk_fast,
    input  wire       init_resetPulse,
    input  wire       cmd_start,
    input  wire cmd_req_t cmd_req,
    input  wire       cmd_in,
    input  wire [3:0] dat_in,
    output logic      sd_clk,
    output line_out_t cmd_out,
    output logic      cmd_done,
    output logic      resp_done,
    output resp_t     resp,
    output logic      word_valid,
    output dat_word_t word,
    output logic      dat_done,
    output logic      dat_crc_err
);

    logic rx_abort;
    logic arm_resp;
    logic arm_dat;

    // Card clock runs at the full system rate
    assign sd_clk = clk_fast;

    sd_cmd_tx u_cmd_tx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_start       (cmd_start),
        .cmd_req         (cmd_req),
        .cmd_out         (cmd_out),
        .cmd_done        (cmd_done),
        .rx_abort        (rx_abort),
        .arm_resp        (arm_resp),
        .arm_dat         (arm_dat)
    );

    sd_resp_rx u_resp_rx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .arm             (arm_resp),
        .abort           (rx_abort),
        .cmd_in          (cmd_in),
        .resp_done       (resp_done),
        .resp            (resp)
    );

    sd_dat_rx u_dat_rx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .arm             (arm_dat),
        .abort           (rx_abort),
        .dat_in          (dat_in),
        .word_valid      (word_valid),
        .word            (word),
        .dat_done        (dat_done),
        .dat_crc_err     (dat_crc_err)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_sd_host -f vlog.f -o sim_tb_sd_host

status=0
./obj_dir/sim_tb_sd_host +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log || [ "$status" -ne 0 ] || ! grep -q "Test passed" sim.log; then
    exit 1
fi
exit 0

/* tb/sd_host_props.sv */
`timescale 1ns/1ns
`default_nettype none

// Timing rules on the sd_host outputs
module sd_host_props
    import sd_pkg::*;
(
    input wire            clk_fast,
    input wire            init_resetPulse,
    input wire            cmd_start,
    input wire line_out_t cmd_out,
    input wire            cmd_done,
    input wire            resp_done,
    input wire            word_valid,
    input wire            dat_done
);

    // Cycles since the last cmd_start, parked at all ones when idle
    logic [6:0]  since_start;
    int unsigned fail_count = 0;

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            since_start <= '1;
        end else if (cmd_start) begin
            since_start <= '0;
        end else if (since_start != '1) begin
            since_start <= since_start + 1'b1;
        end
    end

    // ======================================================================
    // Single-cycle pulses
    // ======================================================================

    a_cmd_done_pulse: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        cmd_done |=> !cmd_done)
        else begin
            $error("cmd_done high for more than one cycle");
            fail_count++;
        end

    a_resp_done_pulse: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        resp_done |=> !resp_done)
        else begin
            $error("resp_done high for more than one cycle");
            fail_count++;
        end

    a_word_valid_pulse: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        word_valid |=> !word_valid)
        else begin
            $error("word_valid high for more than one cycle");
            fail_count++;
        end

    a_dat_done_pulse: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        dat_done |=> !dat_done)
        else begin
            $error("dat_done high for more than one cycle");
            fail_count++;
        end

    // ======================================================================
    // Reset and command window
    // ======================================================================

    a_reset_quiet: assert property (@(posedge clk_fast)
        init_resetPulse |=> !cmd_out.en && !cmd_done && !resp_done && !word_valid && !dat_done)
        else begin
            $error("Outputs not quiet after reset");
            fail_count++;
        end

    // 48 cycles of drive, then nothing until the next command
    a_en_window: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        cmd_out.en == (since_start < CMD_FRAME_BITS))
        else begin
            $error("cmd_out.en outside the 48-cycle command window");
            fail_count++;
        end

    a_done_latency: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        cmd_done == (since_start == CMD_FRAME_BITS))
        else begin
            $error("cmd_done not 48 cycles after cmd_start");
            fail_count++;
        end

endmodule

bind sd_host sd_host_props u_props (
    .clk_fast        (clk_fast),
    .init_resetPulse (init_resetPulse),
    .cmd_start       (cmd_start),
    .cmd_out         (cmd_out),
    .cmd_done        (cmd_done),
    .resp_done       (resp_done),
    .word_valid      (word_valid),
    .dat_done        (dat_done)
);

`default_nettype wire

/* tb/tb_sd_host.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sd_host
    import sd_pkg::*;
();

    localparam int CMD_LIMIT = 64;

    logic      clk_fast;
    logic      init_resetPulse;
    logic      cmd_start;
    cmd_req_t  cmd_req;
    logic      cmd_in;
    logic [3:0] dat_in;
    logic      sd_clk;
    line_out_t cmd_out;
    logic      cmd_done;
    logic      resp_done;
    resp_t     resp;
    logic      word_valid;
    dat_word_t word;
    logic      dat_done;
    logic      dat_crc_err;

    bit [31:0]   lcg_state = 32'h276a_847b;
    dat_word_t   blk_words [BLOCK_NIBBLES/WORD_NIBBLES];
    dat_word_t   words_seen [$];
    int          dat_done_count = 0;
    string       test_name;
    int          test_errs;
    int          tests_run = 0;
    int          tests_failed = 0;
    bit          timed_out = 0;

    sd_host u_sd_host (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_start       (cmd_start),
        .cmd_req         (cmd_req),
        .cmd_in          (cmd_in),
        .dat_in          (dat_in),
        .sd_clk          (sd_clk),
        .cmd_out         (cmd_out),
        .cmd_done        (cmd_done),
        .resp_done       (resp_done),
        .resp            (resp),
        .word_valid      (word_valid),
        .word            (word),
        .dat_done        (dat_done),
        .dat_crc_err     (dat_crc_err)
    );

    initial begin
        clk_fast = 1'b0;
        forever #2 clk_fast = ~clk_fast;
    end

    // Words and block completions, sampled mid-cycle
    always @(negedge clk_fast) begin
        if (word_valid) begin
            words_seen.push_back(word);
        end
        if (dat_done) begin
            dat_done_count++;
        end
    end

    // ======================================================================
    // Card model
    // ======================================================================

    function automatic bit [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // SD CRC7, MSB first, zero start value
    function automatic crc7_t crc7_of(input logic [CMD_PAYLOAD_BITS-1:0] bits);
        crc7_t c;
        logic  fb;
        c = '0;
        for (int i = CMD_PAYLOAD_BITS - 1; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? CRC7_POLY : 7'h00);
        end
        return c;
    endfunction

    function automatic logic [3:0] nibble_at(input int n);
        dat_word_t w;
        w = blk_words[n / WORD_NIBBLES];
        return w[15 - 4 * (n % WORD_NIBBLES) -: 4];
    endfunction

    // CCITT CRC16 of one DAT line over the whole block
    function automatic crc16_t crc16_of_line(input int line);
        crc16_t     c;
        logic       fb;
        logic [3:0] nib;
        c = '0;
        for (int n = 0; n < BLOCK_NIBBLES; n++) begin
            nib = nibble_at(n);
            fb = nib[line] ^ c[15];
            c = {c[14:0], 1'b0} ^ (fb ? CRC16_POLY : 16'h0000);
        end
        return c;
    endfunction

    // Start bit, transmission bit, index, argument, CRC7, end bit
    function automatic logic [47:0] frame_of(input logic tbit, input logic [5:0] index,
                                             input logic [31:0] arg);
        logic [CMD_PAYLOAD_BITS-1:0] payload;
        payload = {1'b0, tbit, index, arg};
        return {payload, crc7_of(payload), 1'b1};
    endfunction

    function automatic cmd_req_t random_req(input logic want_resp, input logic want_block);
        cmd_req_t r;
        r.index        = 6'(lcg_next() >> 20);
        r.arg          = lcg_next();
        r.expect_resp  = want_resp;
        r.expect_block = want_block;
        return r;
    endfunction

    task automatic fill_block();
        for (int i = 0; i < BLOCK_NIBBLES / WORD_NIBBLES; i++) begin
            blk_words[i] = 16'(lcg_next() >> 16);
        end
    endtask

    task automatic drive_response(input logic [47:0] frame);
        for (int i = CMD_FRAME_BITS - 1; i >= 0; i--) begin
            cmd_in = frame[i];
            @(negedge clk_fast);
        end
        cmd_in = 1'b1;
    endtask

    // A short count stops after the data and leaves the lines idle
    task automatic drive_block(input int nibbles, input int bad_line);
        crc16_t crc_tx [4];
        for (int l = 0; l < 4; l++) begin
            crc_tx[l] = crc16_of_line(l);
        end
        if (bad_line >= 0) begin
            crc_tx[bad_line] = crc_tx[bad_line] ^ 16'h0100;
        end
        dat_in = 4'h0;
        @(negedge clk_fast);
        for (int n = 0; n < nibbles; n++) begin
            dat_in = nibble_at(n);
            @(negedge clk_fast);
        end
        dat_in = 4'hf;
        if (nibbles < BLOCK_NIBBLES) begin
            return;
        end
        for (int b = CRC16_BITS - 1; b >= 0; b--) begin
            dat_in = {crc_tx[3][b], crc_tx[2][b], crc_tx[1][b], crc_tx[0][b]};
            @(negedge clk_fast);
        end
        // End nibble
        dat_in = 4'hf;
        @(negedge clk_fast);
    endtask

    // ======================================================================
    // Host side and checking
    // ======================================================================

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            test_errs++;
        end
    endtask

    // Card clock looked at in the middle of each clk_fast phase
    task automatic check_card_clock();
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_fast);
            #1;
            check_value("sd_clk high phase", 1'b1, sd_clk);
            @(negedge clk_fast);
            #1;
            check_value("sd_clk low phase", 1'b0, sd_clk);
        end
        @(negedge clk_fast);
    endtask

    task automatic send_command(input cmd_req_t req, output logic [47:0] frame,
                                output int latency, output int en_cycles);
        int n;
        frame     = '0;
        latency   = 0;
        en_cycles = 0;
        cmd_req   = req;
        cmd_start = 1'b1;
        @(negedge clk_fast);
        cmd_start = 1'b0;
        // Negedge n comes right after rising edge n-1, counted from the one that took cmd_start
        n = 1;
        while (!cmd_done && n < CMD_LIMIT) begin
            if (cmd_out.en) begin
                frame = {frame[46:0], cmd_out.val};
                en_cycles++;
            end
            @(negedge clk_fast);
            n++;
        end
        if (cmd_done) begin
            latency = n - 1;
        end else begin
            $display("Timeout: cmd_done never came in %s", test_name);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_command(input cmd_req_t req, input logic [47:0] frame,
                                 input int latency, input int en_cycles);
        check_value("command frame", frame_of(1'b1, req.index, req.arg), frame);
        check_value("cmd_done latency", CMD_FRAME_BITS, latency);
        check_value("cmd_out.en cycles", CMD_FRAME_BITS, en_cycles);
    endtask

    task automatic run_command(input cmd_req_t req);
        logic [47:0] frame;
        int          lat;
        int          en_cycles;
        send_command(req, frame, lat, en_cycles);
        if (!timed_out) begin
            check_command(req, frame, lat, en_cycles);
        end
    endtask

    task automatic wait_pulse(input logic on_dat, input string what, input int limit);
        int n;
        n = 0;
        while (!(on_dat ? dat_done : resp_done) && n < limit) begin
            @(negedge clk_fast);
            n++;
        end
        if (!(on_dat ? dat_done : resp_done)) begin
            $display("Timeout: %s did not arrive within %0d cycles in %s", what, limit, test_name);
            timed_out = 1'b1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0 && !timed_out) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, test_errs);
        end
    endtask

    // Card answers a few cycles after the command, fault 1 flips a CRC bit, 2 clears the end bit
    task automatic answer_command(input cmd_req_t req, input int fault);
        logic [47:0] sent;
        sent = frame_of(1'b0, req.index, lcg_next());
        if (fault == 1) begin
            sent[3] = ~sent[3];
        end else if (fault == 2) begin
            sent[0] = 1'b0;
        end
        repeat (2 + (lcg_next() >> 29)) @(negedge clk_fast);
        drive_response(sent);
        wait_pulse(1'b0, "resp_done", 4);
        if (!timed_out) begin
            check_value("resp.frame", sent, resp.frame);
            check_value("resp.crc_err", fault != 0, resp.crc_err);
        end
    endtask

    task automatic response_test(input string name, input int fault);
        cmd_req_t req;
        begin_test(name);
        req = random_req(1'b1, 1'b0);
        run_command(req);
        if (!timed_out) begin
            answer_command(req, fault);
        end
        end_test();
    endtask

    task automatic block_test(input string name, input int bad_line);
        begin_test(name);
        fill_block();
        words_seen.delete();
        run_command(random_req(1'b0, 1'b1));
        if (!timed_out) begin
            repeat (2 + (lcg_next() >> 29)) @(negedge clk_fast);
            drive_block(BLOCK_NIBBLES, bad_line);
            wait_pulse(1'b1, "dat_done", 4);
        end
        if (!timed_out) begin
            check_value("word count", BLOCK_NIBBLES / WORD_NIBBLES, words_seen.size());
            for (int i = 0; i < words_seen.size() && i < BLOCK_NIBBLES / WORD_NIBBLES; i++) begin
                check_value($sformatf("word %0d", i), blk_words[i], words_seen[i]);
            end
            check_value("dat_crc_err", bad_line >= 0, dat_crc_err);
        end
        end_test();
    endtask

    task automatic abort_test();
        cmd_req_t req;
        int       done_before;
        begin_test("block_abort");
        fill_block();
        run_command(random_req(1'b0, 1'b1));
        if (!timed_out) begin
            repeat (2 + (lcg_next() >> 29)) @(negedge clk_fast);
            done_before = dat_done_count;
            drive_block(300, -1);
            // New command lands while the block is still open
            req = random_req(1'b1, 1'b0);
            run_command(req);
        end
        if (!timed_out) begin
            answer_command(req, 0);
        end
        if (!timed_out) begin
            // Long enough for the old block to have ended had it not been dropped
            repeat (BLOCK_NIBBLES + 40) @(negedge clk_fast);
            check_value("dat_done count", done_before, dat_done_count);
        end
        end_test();
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        init_resetPulse = 1'b1;
        cmd_start       = 1'b0;
        cmd_req         = '0;
        cmd_in          = 1'b1;
        dat_in          = 4'hf;
        repeat (10) @(negedge clk_fast);
        init_resetPulse = 1'b0;
        @(negedge clk_fast);

        begin_test("card_clock");
        check_card_clock();
        end_test();

        begin_test("command_frame");
        run_command(random_req(1'b0, 1'b0));
        end_test();
        if (!timed_out) response_test("response_ok", 0);
        if (!timed_out) response_test("response_bad_crc", 1);
        if (!timed_out) response_test("response_bad_end", 2);
        if (!timed_out) block_test("block_read", -1);
        if (!timed_out) block_test("block_bad_crc", int'(lcg_next() >> 30));
        if (!timed_out) abort_test();

        $display("Tests run: %0d, with errors: %0d, property failures: %0d",
                 tests_run, tests_failed, u_sd_host.u_props.fail_count);
        if (tests_failed == 0 && !timed_out && u_sd_host.u_props.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
common/sd_pkg.sv
design/sd_crc_lane.sv
cmd/sd_cmd_tx.sv
cmd/sd_resp_rx.sv
dat/sd_dat_rx.sv
design/sd_host.sv
tb/sd_host_props.sv
tb/tb_sd_host.sv
